//--- common/mbox_defs.svh
// mailbox shared definitions
// word and memory geometry, request field widths and the register map
`ifndef MBOX_DEFS_SVH
`define MBOX_DEFS_SVH

// message word width and memory depth in words
`define MBOX_DATA_W 32
`define MBOX_DEPTH  64
// pointer width follows the depth
`define MBOX_PTR_W  $clog2(`MBOX_DEPTH)

// requester attribute and address widths
`define MBOX_USER_W 8
`define MBOX_ADDR_W 8

// register byte addresses, one 32-bit word apart
`define MBOX_LOCK_ADDR    8'h00
`define MBOX_CMD_ADDR     8'h04
`define MBOX_DLEN_ADDR    8'h08
`define MBOX_DATAIN_ADDR  8'h0C
`define MBOX_DATAOUT_ADDR 8'h10
`define MBOX_EXEC_ADDR    8'h14
`define MBOX_STATUS_ADDR  8'h18

`endif

//--- common/mbox_pkg.sv
// mailbox types
// protocol FSM states and the decoded register select
`default_nettype none

package mbox_pkg;

    // protocol states in the order a message moves through them
    // the status register returns this encoding directly
    typedef enum logic [2:0] {
        MBOX_IDLE         = 3'd0,
        MBOX_RDY_FOR_CMD  = 3'd1,
        MBOX_RDY_FOR_DLEN = 3'd2,
        MBOX_RDY_FOR_DATA = 3'd3,
        MBOX_EXECUTE_UC   = 3'd4,
        MBOX_EXECUTE_SOC  = 3'd5
    } mbox_fsm_state_e;

    // register targeted by the current access
    // REG_NONE marks an address outside the map
    typedef enum logic [2:0] {
        REG_LOCK,
        REG_CMD,
        REG_DLEN,
        REG_DATAIN,
        REG_DATAOUT,
        REG_EXEC,
        REG_STATUS,
        REG_NONE
    } mbox_reg_e;

endpackage

`default_nettype wire

//--- common/mbox_req_if.sv
// mailbox requester access
// request fields in, registered response out, four-phase req/ack
`timescale 1ns/1ps
`default_nettype none

`include "mbox_defs.svh"

interface mbox_req_if;

    // request side, stable while req is high
    logic                     req;
    logic                     write;
    logic [`MBOX_ADDR_W-1:0]  addr;
    logic [`MBOX_DATA_W-1:0]  wdata;
    // which side is asking, and its user attribute when it is the soc
    logic                     soc_req;
    logic [`MBOX_USER_W-1:0]  user;

    // response side, valid while ack is high
    logic                     ack;
    logic [`MBOX_DATA_W-1:0]  rdata;
    logic                     error;

    // the register block also needs the requester identity for its ownership check
    modport csr (input req, write, addr, wdata, soc_req, user, output ack, rdata, error);
    modport ctrl (input soc_req, user, wdata);

endinterface

`default_nettype wire

//--- common/mbox_hwif_if.sv
// mailbox register block to controller link
// access strobes one way, protocol state and lock owner the other
`timescale 1ns/1ps
`default_nettype none

`include "mbox_defs.svh"

interface mbox_hwif_if;
    import mbox_pkg::*;

    // strobes from the register block, high for the accept cycle only
    logic                     accept;
    logic                     lock_rd_free;
    logic                     cmd_wr;
    logic                     dlen_wr;
    logic                     datain_wr;
    logic                     dataout_rd;
    // value the execute register holds after this cycle
    logic                     exec_value;

    // controller state seen by the register block
    mbox_fsm_state_e          state;
    logic                     soc_has_lock;
    logic [`MBOX_USER_W-1:0]  lock_user;
    logic                     lock_value;
    logic [`MBOX_DATA_W-1:0]  dataout_data;

    modport csr (output accept, lock_rd_free, cmd_wr, dlen_wr, datain_wr, dataout_rd, exec_value,
                 input state, soc_has_lock, lock_user, lock_value, dataout_data);
    modport ctrl (input accept, lock_rd_free, cmd_wr, dlen_wr, datain_wr, dataout_rd, exec_value,
                  output state, soc_has_lock, lock_user, lock_value, dataout_data);

endinterface

`default_nettype wire

//--- mbox/mbox_sram.sv
// mailbox message memory
// one write port and one registered read port
`timescale 1ns/1ps
`default_nettype none

`include "mbox_defs.svh"

module mbox_sram (
    input  logic                    clk,
    input  logic                    we,
    input  logic [`MBOX_PTR_W-1:0]  waddr,
    input  logic [`MBOX_DATA_W-1:0] wdata,
    input  logic [`MBOX_PTR_W-1:0]  raddr,
    output logic [`MBOX_DATA_W-1:0] rdata
);

    logic [`MBOX_DATA_W-1:0] mem [`MBOX_DEPTH];

    // a read of the word being written returns the old contents
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        rdata <= mem[raddr];
    end

endmodule

`default_nettype wire

//--- mbox/mbox_csr.sv
// mailbox register block
// address decode, four-phase ack, ownership check, cmd/dlen/exec storage
`timescale 1ns/1ps
`default_nettype none

`include "mbox_defs.svh"

module mbox_csr (
    input  logic     clk,
    input  logic     arst_n,
    mbox_req_if.csr  req,
    mbox_hwif_if.csr hw
);
    import mbox_pkg::*;

    mbox_reg_e               sel;
    logic                    accept;
    logic                    in_ready;
    logic                    in_exec;
    logic                    is_owner;
    logic                    is_receiver;
    logic                    allowed;
    logic                    valid;
    logic                    exec_wr;
    logic [`MBOX_DATA_W-1:0] cmd_q;
    logic [`MBOX_DATA_W-1:0] dlen_q;
    logic                    exec_q;
    logic [`MBOX_DATA_W-1:0] rdata_d;

    // a new access starts when req is seen high while ack is still low
    assign accept = req.req & ~req.ack;

    always_comb begin
        case (req.addr)
            `MBOX_LOCK_ADDR:    sel = REG_LOCK;
            `MBOX_CMD_ADDR:     sel = REG_CMD;
            `MBOX_DLEN_ADDR:    sel = REG_DLEN;
            `MBOX_DATAIN_ADDR:  sel = REG_DATAIN;
            `MBOX_DATAOUT_ADDR: sel = REG_DATAOUT;
            `MBOX_EXEC_ADDR:    sel = REG_EXEC;
            `MBOX_STATUS_ADDR:  sel = REG_STATUS;
            default:            sel = REG_NONE;
        endcase
    end

    assign in_ready = hw.state inside {MBOX_RDY_FOR_CMD, MBOX_RDY_FOR_DLEN, MBOX_RDY_FOR_DATA};
    assign in_exec  = hw.state inside {MBOX_EXECUTE_UC, MBOX_EXECUTE_SOC};
    // a soc owner is identified by its user attribute as well
    assign is_owner = hw.soc_has_lock ? (req.soc_req && (req.user == hw.lock_user))
                                      : !req.soc_req;
    // the receiver is the side opposite the owner, named by the execute state
    assign is_receiver = (hw.state == MBOX_EXECUTE_UC) ? !req.soc_req : req.soc_req;

    // lock and status are read-only and open to anyone
    // cmd, dlen and exec read back freely, only writes are guarded
    always_comb begin
        case (sel)
            REG_LOCK, REG_STATUS:
                allowed = !req.write;
            REG_DATAOUT:
                allowed = !req.write && ((in_ready && is_owner) || (in_exec && is_receiver));
            REG_EXEC:
                allowed = !req.write || (in_ready && is_owner) || (in_exec && is_receiver);
            REG_CMD, REG_DLEN, REG_DATAIN:
                allowed = !req.write || (in_ready && is_owner);
            default:
                allowed = 1'b0;
        endcase
    end

    assign valid   = accept & allowed;
    assign exec_wr = valid && req.write && (sel == REG_EXEC);

    // the controller qualifies this one with accept itself
    assign hw.lock_rd_free = (sel == REG_LOCK) && !req.write && !hw.lock_value;
    assign hw.accept       = accept;
    assign hw.cmd_wr       = valid && req.write && (sel == REG_CMD);
    assign hw.dlen_wr      = valid && req.write && (sel == REG_DLEN);
    assign hw.datain_wr    = valid && req.write && (sel == REG_DATAIN);
    assign hw.dataout_rd   = valid && !req.write && (sel == REG_DATAOUT);
    // idle forces execute low so the next owner starts clean
    assign hw.exec_value   = exec_wr ? req.wdata[0] : ((hw.state == MBOX_IDLE) ? 1'b0 : exec_q);

    // lock reads report the value before this access takes it
    always_comb begin
        case (sel)
            REG_LOCK:    rdata_d = {{(`MBOX_DATA_W-1){1'b0}}, hw.lock_value};
            REG_CMD:     rdata_d = cmd_q;
            REG_DLEN:    rdata_d = dlen_q;
            REG_DATAOUT: rdata_d = hw.dataout_data;
            REG_EXEC:    rdata_d = {{(`MBOX_DATA_W-1){1'b0}}, exec_q};
            REG_STATUS:  rdata_d = {{(`MBOX_DATA_W-3){1'b0}}, hw.state};
            default:     rdata_d = '0;
        endcase
    end

    // ack follows req by one cycle in both directions
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            req.ack   <= 1'b0;
            req.error <= 1'b0;
        end else begin
            req.ack <= req.req;
            if (accept) begin
                req.error <= !allowed;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req.rdata <= allowed ? rdata_d : '0;
        end
    end

    // message registers are wiped whenever the mailbox sits idle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cmd_q  <= '0;
            dlen_q <= '0;
            exec_q <= 1'b0;
        end else begin
            exec_q <= hw.exec_value;
            if (hw.state == MBOX_IDLE) begin
                cmd_q  <= '0;
                dlen_q <= '0;
            end else begin
                if (hw.cmd_wr) begin
                    cmd_q <= req.wdata;
                end
                if (hw.dlen_wr) begin
                    dlen_q <= req.wdata;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- mbox/mbox_ctrl.sv
// mailbox controller
// protocol FSM, lock owner, SRAM pointers and data-available outputs
`timescale 1ns/1ps
`default_nettype none

`include "mbox_defs.svh"

module mbox_ctrl (
    input  logic  clk,
    input  logic  arst_n,
    mbox_req_if   req,
    mbox_hwif_if  hw,
    output logic  uc_data_avail,
    output logic  soc_data_avail
);
    import mbox_pkg::*;

    mbox_fsm_state_e         state_q;
    mbox_fsm_state_e         state_d;
    logic                    lock_q;
    logic                    soc_lock_q;
    logic [`MBOX_USER_W-1:0] user_q;
    logic                    take_lock;
    logic                    release_lock;
    logic                    inc_wrptr;
    logic                    inc_rdptr;
    logic [`MBOX_PTR_W-1:0]  wrptr_q;
    logic [`MBOX_PTR_W-1:0]  rdptr_q;

    // lock is taken by an accepted lock read that found it free
    assign take_lock = hw.accept & hw.lock_rd_free;

    always_comb begin
        state_d      = state_q;
        release_lock = 1'b0;
        inc_wrptr    = 1'b0;
        inc_rdptr    = 1'b0;
        case (state_q)
            MBOX_IDLE: begin
                if (take_lock) begin
                    state_d = MBOX_RDY_FOR_CMD;
                end
            end
            MBOX_RDY_FOR_CMD: begin
                if (hw.cmd_wr) begin
                    state_d = MBOX_RDY_FOR_DLEN;
                end
            end
            MBOX_RDY_FOR_DLEN: begin
                if (hw.dlen_wr) begin
                    state_d = MBOX_RDY_FOR_DATA;
                end
            end
            MBOX_RDY_FOR_DATA: begin
                // data words only land in memory during this phase
                inc_wrptr = hw.datain_wr;
                inc_rdptr = hw.dataout_rd;
                // a soc owner hands the message to the uc and vice versa
                if (hw.exec_value) begin
                    state_d = soc_lock_q ? MBOX_EXECUTE_UC : MBOX_EXECUTE_SOC;
                end
            end
            MBOX_EXECUTE_UC, MBOX_EXECUTE_SOC: begin
                inc_rdptr = hw.dataout_rd;
                // receiver clearing execute ends the exchange
                if (!hw.exec_value) begin
                    state_d      = MBOX_IDLE;
                    release_lock = 1'b1;
                end
            end
            default: state_d = MBOX_IDLE;
        endcase
    end

    // owner identity is captured once, when the lock is granted
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q    <= MBOX_IDLE;
            lock_q     <= 1'b0;
            soc_lock_q <= 1'b0;
            user_q     <= '0;
        end else begin
            state_q <= state_d;
            if (take_lock) begin
                lock_q     <= 1'b1;
                soc_lock_q <= req.soc_req;
                user_q     <= req.user;
            end else if (release_lock) begin
                lock_q <= 1'b0;
            end
        end
    end

    // both pointers restart at zero for the next message
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wrptr_q <= '0;
            rdptr_q <= '0;
        end else if (release_lock) begin
            wrptr_q <= '0;
            rdptr_q <= '0;
        end else begin
            if (inc_wrptr) begin
                wrptr_q <= wrptr_q + 1'b1;
            end
            if (inc_rdptr) begin
                rdptr_q <= rdptr_q + 1'b1;
            end
        end
    end

    assign hw.state        = state_q;
    assign hw.lock_value   = lock_q;
    assign hw.soc_has_lock = soc_lock_q;
    assign hw.lock_user    = user_q;

    assign uc_data_avail  = (state_q == MBOX_EXECUTE_UC);
    assign soc_data_avail = (state_q == MBOX_EXECUTE_SOC);

    mbox_csr u_csr (
        .clk    (clk),
        .arst_n (arst_n),
        .req    (req),
        .hw     (hw)
    );

    // read data tracks the read pointer one cycle behind
    mbox_sram u_sram (
        .clk   (clk),
        .we    (inc_wrptr),
        .waddr (wrptr_q),
        .wdata (req.wdata),
        .raddr (rdptr_q),
        .rdata (hw.dataout_data)
    );

endmodule

`default_nettype wire

//--- design/mbox_top.sv
// mailbox top level
// maps the plain requester ports onto the internal interfaces
`timescale 1ns/1ps
`default_nettype none

`include "mbox_defs.svh"

module mbox_top (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    req,
    input  logic                    write,
    input  logic [`MBOX_ADDR_W-1:0] addr,
    input  logic [`MBOX_DATA_W-1:0] wdata,
    input  logic                    soc_req,
    input  logic [`MBOX_USER_W-1:0] user,
    output logic                    ack,
    output logic [`MBOX_DATA_W-1:0] rdata,
    output logic                    error,
    output logic                    uc_data_avail,
    output logic                    soc_data_avail
);

    mbox_req_if  req_if ();
    mbox_hwif_if hwif ();

    // request fields go straight onto the access interface
    assign req_if.req     = req;
    assign req_if.write   = write;
    assign req_if.addr    = addr;
    assign req_if.wdata   = wdata;
    assign req_if.soc_req = soc_req;
    assign req_if.user    = user;

    // response comes back registered from the register block
    assign ack   = req_if.ack;
    assign rdata = req_if.rdata;
    assign error = req_if.error;

    mbox_ctrl u_ctrl (
        .clk            (clk),
        .arst_n         (arst_n),
        .req            (req_if),
        .hw             (hwif),
        .uc_data_avail  (uc_data_avail),
        .soc_data_avail (soc_data_avail)
    );

endmodule

`default_nettype wire

//--- testbench/tb_clkgen.sv
// testbench clock and reset source
// 20 ns clock, active low reset held for the first 5 cycles
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
    output logic clk,
    output logic arst_n
);

    // half period of 10 ns
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // reset releases on a rising edge, away from the falling sample point
    initial begin
        arst_n = 1'b0;
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
    end

endmodule

`default_nettype wire

//--- testbench/tb_mbox.sv
// mailbox testbench
// random uc and soc messages with intruder accesses, checked against a reference model
`timescale 1ns/1ps
`default_nettype none

`include "mbox_defs.svh"

module tb_mbox;
    import mbox_pkg::*;

    localparam int NUM_MSG     = 16;
    // typical accesses in one message and the slowest access in cycles
    localparam int TXN_PER_MSG = 40;
    localparam int CYC_PER_TXN = 8;
    localparam int MAX_CYCLES  = NUM_MSG * TXN_PER_MSG * CYC_PER_TXN + 1000;
    // the two soc user attributes in play
    localparam logic [7:0] USER_A = 8'h11;
    localparam logic [7:0] USER_B = 8'h22;

    logic                    clk;
    logic                    arst_n;
    logic                    req;
    logic                    write;
    logic [`MBOX_ADDR_W-1:0] addr;
    logic [`MBOX_DATA_W-1:0] wdata;
    logic                    soc_req;
    logic [`MBOX_USER_W-1:0] user;
    logic                    ack;
    logic [`MBOX_DATA_W-1:0] rdata;
    logic                    error;
    logic                    uc_data_avail;
    logic                    soc_data_avail;

    // reference model of the mailbox
    mbox_fsm_state_e         m_state;
    logic                    m_lock;
    logic                    m_own_soc;
    logic [7:0]              m_own_user;
    int                      m_wptr;
    int                      m_rptr;
    logic [31:0]             m_cmd;
    logic [31:0]             m_dlen;
    logic                    m_exec;
    logic [31:0]             m_mem [`MBOX_DEPTH];
    // words never written hold unknown memory contents
    logic                    m_written [`MBOX_DEPTH];

    logic [31:0]             lcg_state;
    int                      cycles    = 0;
    int                      err_rdata = 0;
    int                      err_error = 0;
    int                      err_avail = 0;

    tb_clkgen u_clkgen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    mbox_top DUT (
        .clk            (clk),
        .arst_n         (arst_n),
        .req            (req),
        .write          (write),
        .addr           (addr),
        .wdata          (wdata),
        .soc_req        (soc_req),
        .user           (user),
        .ack            (ack),
        .rdata          (rdata),
        .error          (error),
        .uc_data_avail  (uc_data_avail),
        .soc_data_avail (soc_data_avail)
    );

    // upper half of the LCG state, the low bits repeat too quickly
    function automatic logic [15:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[31:16];
    endfunction

    function automatic logic [31:0] rand_word();
        logic [15:0] hi;
        hi = next_rand();
        return {hi, next_rand()};
    endfunction

    // expected response and effect of one access, from the mailbox rules
    task automatic model_access(input logic w, input logic [7:0] a, input logic [31:0] d,
                                input logic soc, input logic [7:0] u,
                                output logic [31:0] exp_rd, output logic exp_err,
                                output logic rd_check);
        logic in_ready;
        logic in_exec;
        logic owner;
        logic receiver;
        logic ok;
        in_ready = m_state inside {MBOX_RDY_FOR_CMD, MBOX_RDY_FOR_DLEN, MBOX_RDY_FOR_DATA};
        in_exec  = m_state inside {MBOX_EXECUTE_UC, MBOX_EXECUTE_SOC};
        owner    = m_own_soc ? (soc && (u == m_own_user)) : !soc;
        // EXECUTE_UC hands the message to the uc side
        receiver = (m_state == MBOX_EXECUTE_UC) ? !soc : soc;
        exp_rd   = '0;
        rd_check = 1'b0;
        case (a)
            `MBOX_LOCK_ADDR: begin
                ok     = !w;
                exp_rd = {31'd0, m_lock};
            end
            `MBOX_CMD_ADDR: begin
                ok     = !w || (in_ready && owner);
                exp_rd = m_cmd;
            end
            `MBOX_DLEN_ADDR: begin
                ok     = !w || (in_ready && owner);
                exp_rd = m_dlen;
            end
            `MBOX_DATAIN_ADDR: ok = !w || (in_ready && owner);
            `MBOX_DATAOUT_ADDR: begin
                ok     = !w && ((in_ready && owner) || (in_exec && receiver));
                exp_rd = m_mem[m_rptr];
            end
            `MBOX_EXEC_ADDR: begin
                ok     = !w || (in_ready && owner) || (in_exec && receiver);
                exp_rd = {31'd0, m_exec};
            end
            `MBOX_STATUS_ADDR: begin
                ok     = !w;
                exp_rd = {29'd0, m_state};
            end
            default: ok = 1'b0;
        endcase
        exp_err  = !ok;
        // datain has no defined read value, and unwritten memory words are unknown
        rd_check = ok && !w && (a != `MBOX_DATAIN_ADDR)
                   && !((a == `MBOX_DATAOUT_ADDR) && !m_written[m_rptr]);
        if (ok) begin
            if (a == `MBOX_LOCK_ADDR && !m_lock) begin
                m_lock     = 1'b1;
                m_own_soc  = soc;
                m_own_user = u;
                m_state    = MBOX_RDY_FOR_CMD;
            end
            if (w && a == `MBOX_CMD_ADDR) begin
                m_cmd = d;
                if (m_state == MBOX_RDY_FOR_CMD) begin
                    m_state = MBOX_RDY_FOR_DLEN;
                end
            end
            if (w && a == `MBOX_DLEN_ADDR) begin
                m_dlen = d;
                if (m_state == MBOX_RDY_FOR_DLEN) begin
                    m_state = MBOX_RDY_FOR_DATA;
                end
            end
            // data words only count once the length is in
            if (w && a == `MBOX_DATAIN_ADDR && m_state == MBOX_RDY_FOR_DATA) begin
                m_mem[m_wptr]     = d;
                m_written[m_wptr] = 1'b1;
                m_wptr            = (m_wptr + 1) % `MBOX_DEPTH;
            end
            if (!w && a == `MBOX_DATAOUT_ADDR && m_state != MBOX_RDY_FOR_CMD
                    && m_state != MBOX_RDY_FOR_DLEN) begin
                m_rptr = (m_rptr + 1) % `MBOX_DEPTH;
            end
            if (w && a == `MBOX_EXEC_ADDR) begin
                m_exec = d[0];
            end
        end
        // execute set early still takes effect once the data phase is reached
        if (m_state == MBOX_RDY_FOR_DATA && m_exec) begin
            m_state = m_own_soc ? MBOX_EXECUTE_UC : MBOX_EXECUTE_SOC;
        end else if (m_state inside {MBOX_EXECUTE_UC, MBOX_EXECUTE_SOC} && !m_exec) begin
            m_state = MBOX_IDLE;
            m_lock  = 1'b0;
            m_wptr  = 0;
            m_rptr  = 0;
            m_cmd   = '0;
            m_dlen  = '0;
        end
    endtask

    // one four-phase transfer on the DUT, then compare with the model
    task automatic bus_access(input logic w, input logic [7:0] a, input logic [31:0] d,
                              input logic soc, input logic [7:0] u);
        logic [31:0] exp_rd;
        logic        exp_err;
        logic        rd_check;
        logic [31:0] got_rd;
        logic        got_err;
        model_access(w, a, d, soc, u, exp_rd, exp_err, rd_check);
        @(posedge clk);
        req     <= 1'b1;
        write   <= w;
        addr    <= a;
        wdata   <= d;
        soc_req <= soc;
        user    <= u;
        do @(negedge clk); while (!ack);
        got_rd  = rdata;
        got_err = error;
        @(posedge clk);
        req <= 1'b0;
        do @(negedge clk); while (ack);
        assert (got_err === exp_err) else begin
            err_error++;
            $display("ERR %0t error expected %0b got %0b (addr %h)", $time, exp_err, got_err, a);
        end
        if (rd_check) begin
            assert (got_rd === exp_rd) else begin
                err_rdata++;
                $display("ERR %0t rdata expected %h got %h (addr %h)", $time, exp_rd, got_rd, a);
            end
        end
        assert (uc_data_avail === (m_state == MBOX_EXECUTE_UC)) else begin
            err_avail++;
            $display("ERR %0t uc_data_avail expected %0b got %0b", $time,
                     m_state == MBOX_EXECUTE_UC, uc_data_avail);
        end
        assert (soc_data_avail === (m_state == MBOX_EXECUTE_SOC)) else begin
            err_avail++;
            $display("ERR %0t soc_data_avail expected %0b got %0b", $time,
                     m_state == MBOX_EXECUTE_SOC, soc_data_avail);
        end
    endtask

    // access by a party with no right to change the mailbox right now
    task automatic intrude();
        logic [15:0] r;
        logic [7:0]  a;
        logic        soc;
        logic [7:0]  u;
        r = next_rand();
        case (r[2:0])
            3'd0: a = `MBOX_LOCK_ADDR;
            3'd1: a = `MBOX_CMD_ADDR;
            3'd2: a = `MBOX_DLEN_ADDR;
            3'd3: a = `MBOX_DATAIN_ADDR;
            3'd4: a = `MBOX_DATAOUT_ADDR;
            3'd5: a = `MBOX_EXEC_ADDR;
            3'd6: a = `MBOX_STATUS_ADDR;
            default: a = r[3] ? 8'h1C : 8'h06;
        endcase
        u = r[6] ? USER_B : USER_A;
        if (m_state inside {MBOX_EXECUTE_UC, MBOX_EXECUTE_SOC}) begin
            // the sending side is locked out while the receiver works
            soc = m_own_soc;
            u   = m_own_user;
        end else if (m_own_soc) begin
            soc = r[5];
            u   = (m_own_user == USER_A) ? USER_B : USER_A;
        end else begin
            soc = 1'b1;
        end
        bus_access(r[4], a, rand_word(), soc, u);
    endtask

    // roughly one step in four is followed by an intruder
    task automatic maybe_intrude();
        logic [15:0] r;
        r = next_rand();
        if (r[1:0] == 2'd0) begin
            intrude();
        end
    endtask

    task automatic send_message(input logic own_soc, input logic [7:0] own_user, input int len);
        logic [15:0] r;
        logic [7:0]  rx_user;
        r       = next_rand();
        rx_user = r[0] ? USER_B : USER_A;
        bus_access(1'b0, `MBOX_LOCK_ADDR, '0, own_soc, own_user);
        maybe_intrude();
        // a second lock read by anyone finds it taken
        bus_access(1'b0, `MBOX_LOCK_ADDR, '0, r[1], rx_user);
        bus_access(1'b0, `MBOX_STATUS_ADDR, '0, own_soc, own_user);
        bus_access(1'b1, `MBOX_CMD_ADDR, rand_word(), own_soc, own_user);
        maybe_intrude();
        bus_access(1'b1, `MBOX_DLEN_ADDR, len, own_soc, own_user);
        bus_access(1'b0, `MBOX_CMD_ADDR, '0, own_soc, own_user);
        bus_access(1'b0, `MBOX_DLEN_ADDR, '0, own_soc, own_user);
        bus_access(1'b0, `MBOX_EXEC_ADDR, '0, own_soc, own_user);
        for (int i = 0; i < len; i++) begin
            bus_access(1'b1, `MBOX_DATAIN_ADDR, rand_word(), own_soc, own_user);
            maybe_intrude();
        end
        bus_access(1'b1, `MBOX_EXEC_ADDR, 32'd1, own_soc, own_user);
        maybe_intrude();
        for (int i = 0; i < len; i++) begin
            bus_access(1'b0, `MBOX_DATAOUT_ADDR, '0, !own_soc, rx_user);
            maybe_intrude();
        end
        // receiver ends execute and frees the lock
        bus_access(1'b1, `MBOX_EXEC_ADDR, 32'd0, !own_soc, rx_user);
    endtask

    // run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        logic [15:0] r;
        int          total;
        lcg_state  = 32'd63149;
        m_state    = MBOX_IDLE;
        m_lock     = 1'b0;
        m_own_soc  = 1'b0;
        m_own_user = '0;
        m_wptr     = 0;
        m_rptr     = 0;
        m_cmd      = '0;
        m_dlen     = '0;
        m_exec     = 1'b0;
        for (int i = 0; i < `MBOX_DEPTH; i++) begin
            m_written[i] = 1'b0;
        end
        req     <= 1'b0;
        write   <= 1'b0;
        addr    <= '0;
        wdata   <= '0;
        soc_req <= 1'b0;
        user    <= '0;
        @(posedge arst_n);
        repeat (2) @(posedge clk);
        for (int m = 0; m < NUM_MSG; m++) begin
            r = next_rand();
            send_message(r[9], r[3] ? USER_B : USER_A, 32'(r[7:4]) + 1);
        end
        // idle mailbox rejects read-only writes and unmapped addresses
        bus_access(1'b1, `MBOX_STATUS_ADDR, 32'd3, 1'b1, USER_A);
        bus_access(1'b1, `MBOX_LOCK_ADDR, 32'd1, 1'b0, USER_A);
        bus_access(1'b1, `MBOX_DATAOUT_ADDR, 32'd1, 1'b0, USER_A);
        bus_access(1'b0, 8'h40, '0, 1'b1, USER_B);
        bus_access(1'b1, `MBOX_CMD_ADDR, 32'd7, 1'b1, USER_B);
        total = err_rdata + err_error + err_avail;
        $display("errors: rdata %0d, error %0d, data_avail %0d, total %0d",
                 err_rdata, err_error, err_avail, total);
        if (total == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
+incdir+common
common/mbox_pkg.sv
common/mbox_req_if.sv
common/mbox_hwif_if.sv
mbox/mbox_sram.sv
mbox/mbox_csr.sv
mbox/mbox_ctrl.sv
design/mbox_top.sv
testbench/tb_clkgen.sv
testbench/tb_mbox.sv

//--- Makefile
# Verilator simulation of the mailbox testbench
VERILATOR ?= verilator
TOP       ?= tb_mbox
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_STR  ?= TEST RESULT: PASS

.PHONY: sim clean

# the run passes only if the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_STR)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
